// File: all.f
+incdir+verilog
verilog/isp_pkg.sv
verilog/axi4s_to_img.sv
verilog/img_demosaic_2x2.sv
verilog/img_to_axi4s.sv
verilog/isp_top.sv
test/tb_clock.sv
test/isp_assert.sv
test/tb_isp_top.sv

// File: run.sh
#!/bin/sh
# Builds the image pipeline testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module tb_isp_top

out=$(./obj_dir/Vtb_isp_top +verilator+error+limit+10000) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "No errors"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: test/tb_isp_top.sv
// Testbench for the image pipeline top level.
// Sends one flat frame and two Bayer colour frames with random input gaps
// and output stalls. The bound assertions check each beat, this module
// checks the beat count per frame.

`timescale 1ns/1ps

`include "isp_cfg.svh"

module tb_isp_top;
    import isp_pkg::*;

    localparam int FRAME_BEATS    = `ISP_X_NUM * `ISP_Y_NUM;
    localparam int NUM_FRAMES     = 3;
    localparam int TOTAL_BEATS    = NUM_FRAMES * FRAME_BEATS;
    localparam int RST_CYCLES     = 10;
    localparam int DRAIN_CYCLES   = 20;
    // Four cycles per beat for stalls over all frames, plus margin.
    localparam int TIMEOUT_CYCLES = 4000;

    localparam logic [`ISP_RAW_W-1:0] RAW_FLAT = 10'h2A8;
    localparam logic [`ISP_RAW_W-1:0] RAW_R    = 10'h100;
    localparam logic [`ISP_RAW_W-1:0] RAW_G    = 10'h200;
    localparam logic [`ISP_RAW_W-1:0] RAW_B    = 10'h300;

    logic      clk;
    logic      i_rst_n;
    raw_beat_t i_s_axis;
    logic      i_s_tvalid;
    logic      o_s_tready;
    rgb_beat_t o_m_axis;
    logic      o_m_tvalid;
    logic      i_m_tready;

    raw_beat_t pix_q[$];
    logic      src_accept;
    int        out_beats;
    int        frame_idx;
    int        frame_beats [NUM_FRAMES];
    int        err_cnt;
    int        cycle_cnt = 0;

    tb_clock #(.PERIOD_NS(100)) u_clock (.clk(clk));

    isp_top DUT (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_s_axis   (i_s_axis),
        .i_s_tvalid (i_s_tvalid),
        .o_s_tready (o_s_tready),
        .o_m_axis   (o_m_axis),
        .o_m_tvalid (o_m_tvalid),
        .i_m_tready (i_m_tready)
    );

    bind isp_top isp_assert u_isp_assert (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .o_s_tready (o_s_tready),
        .o_m_axis   (o_m_axis),
        .o_m_tvalid (o_m_tvalid),
        .i_m_tready (i_m_tready)
    );

    // Level of a colour frame pixel from its place in the Bayer cell.
    function automatic logic [`ISP_RAW_W-1:0] bayer_level(input int x, input int y);
        logic [1:0]            ph;
        logic                  xo;
        logic                  yo;
        logic [`ISP_RAW_W-1:0] lvl;
        ph  = `ISP_BAYER_PHASE;
        xo  = x[0] ^ ph[0];
        yo  = y[0] ^ ph[1];
        lvl = RAW_G;
        if (!xo && !yo) begin
            lvl = RAW_R;
        end else if (xo && yo) begin
            lvl = RAW_B;
        end
        return lvl;
    endfunction

    task automatic fill_frames();
        raw_beat_t beat;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int y = 0; y < `ISP_Y_NUM; y++) begin
                for (int x = 0; x < `ISP_X_NUM; x++) begin
                    beat.tuser = (x == 0) && (y == 0);
                    beat.tlast = (x == `ISP_X_NUM - 1);
                    beat.data  = (f == 0) ? RAW_FLAT : bayer_level(x, y);
                    pix_q.push_back(beat);
                end
            end
        end
    endtask

    // Holds the beat until it is taken, then maybe inserts a gap.
    task automatic drive_source();
        if (src_accept) begin
            void'(pix_q.pop_front());
            i_s_tvalid = 1'b0;
        end
        if (!i_s_tvalid && pix_q.size() != 0 && $urandom_range(3) != 0) begin
            i_s_axis   = pix_q[0];
            i_s_tvalid = 1'b1;
        end
    endtask

    task automatic check_counts();
        for (int f = 0; f < NUM_FRAMES; f++) begin
            if (frame_beats[f] != FRAME_BEATS) begin
                $display("ERROR at %0t: frame %0d gave %0d output beats, expected %0d",
                         $time, f, frame_beats[f], FRAME_BEATS);
                err_cnt++;
            end
        end
        if (out_beats != TOTAL_BEATS) begin
            $display("ERROR at %0t: %0d output beats in total, expected %0d",
                     $time, out_beats, TOTAL_BEATS);
            err_cnt++;
        end
    endtask

    // ########################################################################
    // Handshake monitor and timeout
    // ########################################################################

    always @(posedge clk) begin
        if (i_rst_n) begin
            src_accept = i_s_tvalid && o_s_tready;
            if (o_m_tvalid && i_m_tready) begin
                if (o_m_axis.tuser) begin
                    frame_idx = frame_idx + 1;
                end
                if (frame_idx >= 0 && frame_idx < NUM_FRAMES) begin
                    frame_beats[frame_idx] = frame_beats[frame_idx] + 1;
                end
                out_beats = out_beats + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: output stream incomplete after %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h53cd_9ab5));
        i_rst_n    = 1'b0;
        i_s_axis   = '0;
        i_s_tvalid = 1'b0;
        i_m_tready = 1'b0;
        src_accept = 1'b0;
        out_beats  = 0;
        frame_idx  = -1;
        err_cnt    = 0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            frame_beats[f] = 0;
        end
        fill_frames();
        repeat (RST_CYCLES) @(negedge clk);
        i_rst_n = 1'b1;
        while (out_beats < TOTAL_BEATS) begin
            @(negedge clk);
            drive_source();
            i_m_tready = ($urandom_range(3) != 0);
        end
        repeat (DRAIN_CYCLES) begin                 // Catch stray beats.
            @(negedge clk);
            drive_source();
            i_m_tready = 1'b1;
        end
        check_counts();
        $display("Checks: %0d beat count errors, %0d assertion failures",
                 err_cnt, DUT.u_isp_assert.fail_total);
        if (err_cnt == 0 && DUT.u_isp_assert.fail_total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: test/isp_assert.sv
// Output checks for the image pipeline, bound into isp_top by the testbench.
// Tracks the position of each output beat and checks flags, pixel values
// and the stall behavior against the test frames.

`timescale 1ns/1ps

`include "isp_cfg.svh"

module isp_assert (
    input logic               clk,
    input logic               i_rst_n,
    input logic               o_s_tready,
    input isp_pkg::rgb_beat_t o_m_axis,
    input logic               o_m_tvalid,
    input logic               i_m_tready
);
    import isp_pkg::*;

    localparam int X_NUM       = `ISP_X_NUM;
    localparam int FRAME_BEATS = `ISP_X_NUM * `ISP_Y_NUM;
    localparam int RGB_W       = `ISP_RGB_W;
    localparam int SHIFT       = `ISP_RAW_W - `ISP_RGB_W;

    // Raw test levels seen through the width cut.
    localparam logic [RGB_W-1:0] FLAT_OUT = RGB_W'(10'h2A8 >> SHIFT);
    localparam logic [RGB_W-1:0] R_OUT    = RGB_W'(10'h100 >> SHIFT);
    localparam logic [RGB_W-1:0] G_OUT    = RGB_W'(10'h200 >> SHIFT);
    localparam logic [RGB_W-1:0] B_OUT    = RGB_W'(10'h300 >> SHIFT);

    logic        xfer;
    int unsigned beat_cnt;
    int unsigned frame_no;
    int unsigned pix_no;
    int unsigned fail_reset = 0;
    int unsigned fail_flat = 0;
    int unsigned fail_colour = 0;
    int unsigned fail_flags = 0;
    int unsigned fail_stall = 0;
    int unsigned fail_total;

    assign xfer       = o_m_tvalid && i_m_tready;
    assign frame_no   = beat_cnt / FRAME_BEATS;
    assign pix_no     = beat_cnt % FRAME_BEATS;
    assign fail_total = fail_reset + fail_flat + fail_colour + fail_flags + fail_stall;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            beat_cnt <= 0;
        end else if (xfer) begin
            beat_cnt <= beat_cnt + 1;
        end
    end

    // ########################################################################
    // Checks
    // ########################################################################

    a_reset_idle: assert property (@(posedge clk) $rose(i_rst_n) |-> !o_m_tvalid && o_s_tready)
        else begin
            fail_reset++;
            $error("output valid high or input not ready right after reset");
        end

    a_flat_frame: assert property (@(posedge clk) disable iff (!i_rst_n)
        xfer && frame_no == 0 |->
            o_m_axis.r == FLAT_OUT && o_m_axis.g == FLAT_OUT && o_m_axis.b == FLAT_OUT)
        else begin
            fail_flat++;
            $error("flat frame pixel %0d has wrong RGB", pix_no);
        end

    // Edge pixels reuse their own row or column, so only inner ones are exact.
    a_colour_frame: assert property (@(posedge clk) disable iff (!i_rst_n)
        xfer && frame_no != 0 && pix_no >= X_NUM && (pix_no % X_NUM) != 0 |->
            o_m_axis.r == R_OUT && o_m_axis.g == G_OUT && o_m_axis.b == B_OUT)
        else begin
            fail_colour++;
            $error("colour frame %0d pixel %0d has wrong RGB", frame_no, pix_no);
        end

    a_frame_flags: assert property (@(posedge clk) disable iff (!i_rst_n)
        xfer |-> o_m_axis.tuser == (pix_no == 0)
            && o_m_axis.tlast == ((pix_no % X_NUM) == X_NUM - 1))
        else begin
            fail_flags++;
            $error("tuser or tlast wrong on beat %0d of frame %0d", pix_no, frame_no);
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_m_tvalid && !i_m_tready |=> o_m_tvalid && $stable(o_m_axis))
        else begin
            fail_stall++;
            $error("output beat changed while stalled");
        end

endmodule

// File: test/tb_clock.sv
// Free-running testbench clock.
// The period is set by parameter; the clock starts low.

`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

// File: verilog/isp_top.sv
// Top level of the camera image pipeline.
// Raw Bayer stream in, 8-bit RGB stream out, four enabled cycles of latency.
// All stages share the clock enable made by the output stage.

`timescale 1ns/1ps

module isp_top (
    input  logic               clk,
    input  logic               i_rst_n,

    input  isp_pkg::raw_beat_t i_s_axis,
    input  logic               i_s_tvalid,
    output logic               o_s_tready,

    output isp_pkg::rgb_beat_t o_m_axis,
    output logic               o_m_tvalid,
    input  logic               i_m_tready
);
    import isp_pkg::*;

    logic     cke;
    img_raw_t img_raw;
    img_rgb_t img_rgb;

    assign o_s_tready = cke;                    // Input taken when enabled.

    axi4s_to_img u_src (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_cke      (cke),
        .i_s_axis   (i_s_axis),
        .i_s_tvalid (i_s_tvalid),
        .o_img      (img_raw)
    );

    img_demosaic_2x2 u_demosaic (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_cke      (cke),
        .i_img      (img_raw),
        .o_img      (img_rgb)
    );

    img_to_axi4s u_sink (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_img      (img_rgb),
        .o_cke      (cke),
        .o_m_axis   (o_m_axis),
        .o_m_tvalid (o_m_tvalid),
        .i_m_tready (i_m_tready)
    );

endmodule

// File: verilog/img_to_axi4s.sv
// Stream sink of the pipeline.
// Narrows RGB to the output width and holds one output beat. Its state
// gives the clock enable that stalls every stage upstream.

`timescale 1ns/1ps

`include "isp_cfg.svh"

module img_to_axi4s (
    input  logic               clk,
    input  logic               i_rst_n,
    input  isp_pkg::img_rgb_t  i_img,
    output logic               o_cke,
    output isp_pkg::rgb_beat_t o_m_axis,
    output logic               o_m_tvalid,
    input  logic               i_m_tready
);
    import isp_pkg::*;

    localparam int RW = `ISP_RAW_W;
    localparam int CW = `ISP_RGB_W;

    rgb_beat_t beat_d;

    // Advance when the register is empty or being drained.
    assign o_cke = !o_m_tvalid || i_m_tready;

    always_comb begin
        beat_d.tuser = i_img.flags.row_first && i_img.flags.col_first;
        beat_d.tlast = i_img.flags.col_last;
        beat_d.r     = i_img.r[RW-1 -: CW];     // Keep the top bits.
        beat_d.g     = i_img.g[RW-1 -: CW];
        beat_d.b     = i_img.b[RW-1 -: CW];
    end

    // ########################################################################
    // Output register
    // ########################################################################

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_m_tvalid <= 1'b0;
        end else if (o_cke) begin
            o_m_tvalid <= i_img.de;
        end
    end

    // Held while stalled.
    always_ff @(posedge clk) begin
        if (o_cke) begin
            o_m_axis <= beat_d;
        end
    end

endmodule

// File: verilog/img_demosaic_2x2.sv
// Bayer to RGB reconstruction over a 2x2 window.
// A one-line buffer and one pixel delay per row form the window; stage 1
// registers the window and its colour phase, stage 2 registers r, g, b.
// Edge pixels reuse the current row or column in place of the missing one.

`timescale 1ns/1ps

`include "isp_cfg.svh"

module img_demosaic_2x2 (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_cke,
    input  isp_pkg::img_raw_t i_img,
    output isp_pkg::img_rgb_t o_img
);
    import isp_pkg::*;

    localparam int XW = $clog2(`ISP_X_NUM);
    localparam int RW = `ISP_RAW_W;

    logic [RW-1:0] line_mem [`ISP_X_NUM];       // Previous row.
    logic [XW-1:0] x_cnt;
    logic          y_odd_q;
    logic [XW-1:0] x;
    logic          y_odd;
    logic          pix_en;

    logic [RW-1:0] cur;
    logic [RW-1:0] up;
    logic [RW-1:0] left;
    logic [RW-1:0] up_left;
    logic [RW-1:0] left_q;
    logic [RW-1:0] up_left_q;

    logic          s1_de;
    img_flags_t    s1_flags;
    logic [RW-1:0] s1_w00;                      // (x-1,y-1)
    logic [RW-1:0] s1_w01;                      // (x,y-1)
    logic [RW-1:0] s1_w10;                      // (x-1,y)
    logic [RW-1:0] s1_w11;                      // (x,y)
    bayer_phase_t  s1_phase;

    logic [RW:0]   g_sum;
    logic [RW-1:0] r_d;
    logic [RW-1:0] g_d;
    logic [RW-1:0] b_d;

    logic          s2_de;
    img_flags_t    s2_flags;
    logic [RW-1:0] s2_r;
    logic [RW-1:0] s2_g;
    logic [RW-1:0] s2_b;

    assign pix_en = i_cke && i_img.de;

    // ########################################################################
    // Window formation
    // ########################################################################

    assign x     = i_img.flags.col_first ? '0 : x_cnt;
    assign y_odd = i_img.flags.row_first ? 1'b0 : y_odd_q;

    assign cur     = i_img.data;
    assign up      = i_img.flags.row_first ? cur : line_mem[x];
    assign left    = i_img.flags.col_first ? cur : left_q;
    assign up_left = i_img.flags.col_first ? up : up_left_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            x_cnt   <= '0;
            y_odd_q <= 1'b0;
        end else if (pix_en) begin
            x_cnt   <= x + 1'b1;
            y_odd_q <= i_img.flags.col_last ? ~y_odd : y_odd;
        end
    end

    // Read happens before the write of the same column.
    always_ff @(posedge clk) begin
        if (pix_en) begin
            line_mem[x] <= cur;
            left_q      <= cur;
            up_left_q   <= up;
        end
    end

    // ########################################################################
    // Stage 1: window and colour phase
    // ########################################################################

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s1_de <= 1'b0;
            s2_de <= 1'b0;
        end else if (i_cke) begin
            s1_de <= i_img.de;
            s2_de <= s1_de;
        end
    end

    // Top-left of the window sits at (x-1,y-1), so both parities flip.
    always_ff @(posedge clk) begin
        if (i_cke) begin
            s1_flags <= i_img.flags;
            s1_w00   <= up_left;
            s1_w01   <= up;
            s1_w10   <= left;
            s1_w11   <= cur;
            s1_phase <= bayer_phase_t'(`ISP_BAYER_PHASE ^ {~y_odd, ~x[0]});
        end
    end

    // ########################################################################
    // Stage 2: colour reconstruction
    // ########################################################################

    always_comb begin
        r_d   = s1_w00;
        b_d   = s1_w11;
        g_sum = {1'b0, s1_w01} + {1'b0, s1_w10};
        case (s1_phase)
            BAYER_GRBG: begin
                r_d   = s1_w01;
                b_d   = s1_w10;
                g_sum = {1'b0, s1_w00} + {1'b0, s1_w11};
            end
            BAYER_GBRG: begin
                r_d   = s1_w10;
                b_d   = s1_w01;
                g_sum = {1'b0, s1_w00} + {1'b0, s1_w11};
            end
            BAYER_BGGR: begin
                r_d = s1_w11;
                b_d = s1_w00;
            end
            default: begin
            end
        endcase
        g_d = g_sum[RW:1];                      // Mean, truncated.
    end

    always_ff @(posedge clk) begin
        if (i_cke) begin
            s2_flags <= s1_flags;
            s2_r     <= r_d;
            s2_g     <= g_d;
            s2_b     <= b_d;
        end
    end

    assign o_img = '{flags: s2_flags, de: s2_de, r: s2_r, g: s2_g, b: s2_b};

endmodule

// File: verilog/axi4s_to_img.sv
// Stream source of the pipeline.
// Takes raw Bayer beats and puts them on the image bus with row and column
// flags. One register stage, advanced by the shared clock enable.

`timescale 1ns/1ps

`include "isp_cfg.svh"

module axi4s_to_img (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_cke,
    input  isp_pkg::raw_beat_t i_s_axis,
    input  logic               i_s_tvalid,
    output isp_pkg::img_raw_t  o_img
);
    import isp_pkg::*;

    localparam int XW = $clog2(`ISP_X_NUM);
    localparam int YW = $clog2(`ISP_Y_NUM);

    logic [XW-1:0]         col_cnt;
    logic [YW-1:0]         row_cnt;
    logic [XW-1:0]         col;
    logic [YW-1:0]         row;
    logic                  accept;
    img_flags_t            flags;

    logic                  de_q;
    img_flags_t            flags_q;
    logic [`ISP_RAW_W-1:0] data_q;

    assign accept = i_cke && i_s_tvalid;

    // Frame start forces position zero.
    assign col = i_s_axis.tuser ? '0 : col_cnt;
    assign row = i_s_axis.tuser ? '0 : row_cnt;

    always_comb begin
        flags.row_first = (row == '0);
        flags.row_last  = (row == YW'(`ISP_Y_NUM - 1));
        flags.col_first = (col == '0);          // Also right after tlast.
        flags.col_last  = i_s_axis.tlast;
    end

    // ########################################################################
    // Position counters
    // ########################################################################

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (accept) begin
            if (i_s_axis.tlast) begin
                col_cnt <= '0;
                row_cnt <= flags.row_last ? '0 : row + 1'b1;
            end else begin
                col_cnt <= col + 1'b1;
            end
        end
    end

    // ########################################################################
    // Image bus register
    // ########################################################################

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            de_q <= 1'b0;
        end else if (i_cke) begin
            de_q <= i_s_tvalid;                 // Gap becomes a bubble.
        end
    end

    always_ff @(posedge clk) begin
        if (i_cke) begin
            flags_q <= flags;
            data_q  <= i_s_axis.data;
        end
    end

    assign o_img = '{flags: flags_q, de: de_q, data: data_q};

endmodule

// File: verilog/isp_pkg.sv
// Types shared by the image pipeline blocks.
// Holds the stream beats at both ends and the internal image bus words.
// Modules import it in their bodies and use scoped names in port lists.

`include "isp_cfg.svh"

package isp_pkg;

    // Colour order of a 2x2 cell, top-left first.
    // Bit 0 flips the cell in x, bit 1 flips it in y.
    typedef enum logic [1:0] {
        BAYER_RGGB = 2'd0,
        BAYER_GRBG = 2'd1,
        BAYER_GBRG = 2'd2,
        BAYER_BGGR = 2'd3
    } bayer_phase_t;

    // ########################################################################
    // Stream beats
    // ########################################################################

    typedef struct packed {
        logic                  tuser;          // First pixel of frame.
        logic                  tlast;          // Last pixel of line.
        logic [`ISP_RAW_W-1:0] data;
    } raw_beat_t;

    typedef struct packed {
        logic                  tuser;
        logic                  tlast;
        logic [`ISP_RGB_W-1:0] r;
        logic [`ISP_RGB_W-1:0] g;
        logic [`ISP_RGB_W-1:0] b;
    } rgb_beat_t;

    // ########################################################################
    // Image bus
    // ########################################################################

    typedef struct packed {
        logic row_first;
        logic row_last;
        logic col_first;
        logic col_last;
    } img_flags_t;

    typedef struct packed {
        img_flags_t            flags;
        logic                  de;             // Slot holds a pixel.
        logic [`ISP_RAW_W-1:0] data;
    } img_raw_t;

    typedef struct packed {
        img_flags_t            flags;
        logic                  de;
        logic [`ISP_RAW_W-1:0] r;
        logic [`ISP_RAW_W-1:0] g;
        logic [`ISP_RAW_W-1:0] b;
    } img_rgb_t;

endpackage

// File: verilog/isp_cfg.svh
// Build settings for the Bayer demosaic pipeline.
// Included by the package and by every module that needs frame size,
// data widths or the sensor colour phase.

`ifndef ISP_CFG_SVH
`define ISP_CFG_SVH

// ############################################################################
// Frame geometry
// ############################################################################

`define ISP_X_NUM       16                      // Pixels per line.
`define ISP_Y_NUM       8                       // Lines per frame.

// ############################################################################
// Data widths and sensor phase
// ############################################################################

`define ISP_RAW_W       10                      // Raw sensor pixel.
`define ISP_RGB_W       8                       // Output channel.

// Colour of pixel (0,0), a bayer_phase_t value.
`define ISP_BAYER_PHASE isp_pkg::BAYER_RGGB

`endif
